// File: logic/cavlc_consts.svh
`ifndef CAVLC_CONSTS_SVH
`define CAVLC_CONSTS_SVH

// counting lanes working in parallel.
`define CAVLC_LANES 4

// coefficients in one 4x4 block.
`define CAVLC_BLK_COEFFS 16

// width of the count fields, holds 0..16.
`define CAVLC_CNT_W 5

// width of the block position.
`define CAVLC_POS_W 10

`endif

// File: logic/cavlc_pkg.sv
`include "cavlc_consts.svh"

package cavlc_pkg;

    // quantized coefficient, already clipped to 8 bits.
    typedef logic signed [7:0] coeff_t;

    // one block request, coeffs[0] is DC.
    typedef struct packed {
        coeff_t [`CAVLC_BLK_COEFFS-1:0] coeffs;
        logic [`CAVLC_POS_W-1:0]        topleft_x;
        logic [`CAVLC_POS_W-1:0]        topleft_y;
        logic                           enc_slice_header;
        logic                           enc_mb_header;
    } blk_req_t;

    // statistics of one block, lists filled in scan order.
    typedef struct packed {
        logic [`CAVLC_CNT_W-1:0]             total_coeff;
        logic [`CAVLC_CNT_W-1:0]             total_zeros;
        logic [1:0]                          trailing_ones;
        logic [2:0]                          t1_signs;
        logic [`CAVLC_CNT_W-1:0]             level_cnt;
        coeff_t [`CAVLC_BLK_COEFFS-1:0]      levels;
        logic [`CAVLC_CNT_W-1:0]             run_cnt;
        logic [`CAVLC_BLK_COEFFS-1:0][3:0]   runs;
        logic [`CAVLC_POS_W-1:0]             topleft_x;
        logic [`CAVLC_POS_W-1:0]             topleft_y;
        logic                                enc_slice_header;
        logic                                enc_mb_header;
    } cavlc_stats_t;

endpackage

// File: logic/cavlc_skid.sv
module cavlc_skid #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    logic     main_valid_q;
    logic     spare_valid_q;
    payload_t main_data_q;
    payload_t spare_data_q;
    logic     main_free;

    // main register can take a word this cycle.
    assign main_free = out_ready_i || !main_valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid_q  <= 1'b0;
            spare_valid_q <= 1'b0;
        end else if (main_free) begin
            main_valid_q  <= spare_valid_q || in_valid_i;
            spare_valid_q <= 1'b0;
        end else if (in_valid_i && !spare_valid_q) begin
            spare_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_data_q <= spare_valid_q ? spare_data_q : in_data_i;
        end
        if (!spare_valid_q) begin
            spare_data_q <= in_data_i;
        end
    end

    assign in_ready_o  = !spare_valid_q;
    assign out_valid_o = main_valid_q;
    assign out_data_o  = main_data_q;

endmodule

// File: logic/cavlc_dispatch.sv
`include "cavlc_consts.svh"

module cavlc_dispatch (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     blk_valid_i,
    input  cavlc_pkg::blk_req_t      blk_i,
    output logic                     blk_ready_o,
    output logic [`CAVLC_LANES-1:0]  lane_valid_o,
    output cavlc_pkg::blk_req_t      lane_blk_o,
    input  logic [`CAVLC_LANES-1:0]  lane_ready_i
);

    localparam int LANES = `CAVLC_LANES;
    localparam int SEL_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [SEL_W-1:0] sel_q;
    logic             xfer;

    // only the selected lane may take the block, keeps order.
    always_comb begin
        lane_valid_o        = '0;
        lane_valid_o[sel_q] = blk_valid_i;
    end

    assign lane_blk_o  = blk_i;
    assign blk_ready_o = lane_ready_i[sel_q];
    assign xfer        = blk_valid_i && blk_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else if (xfer) begin
            if (sel_q == SEL_W'(LANES - 1)) begin
                sel_q <= '0;
            end else begin
                sel_q <= sel_q + SEL_W'(1);
            end
        end
    end

endmodule

// File: logic/cavlc_block_counter.sv
`include "cavlc_consts.svh"

module cavlc_block_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   blk_valid_i,
    input  cavlc_pkg::blk_req_t    blk_i,
    output logic                   blk_ready_o,
    output logic                   stat_valid_o,
    output cavlc_pkg::cavlc_stats_t stat_o,
    input  logic                   stat_ready_i
);

    localparam int N     = `CAVLC_BLK_COEFFS;
    localparam int IDX_W = $clog2(N);
    localparam int CNT_W = `CAVLC_CNT_W;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SCAN,
        DONE
    } state_t;

    state_t                  state_q;
    state_t                  state_next;
    logic [IDX_W-1:0]        scan_idx_q;
    logic                    seen_nz_q;
    logic                    t1_stop_q;
    logic [3:0]              zero_run_q;
    cavlc_pkg::blk_req_t     blk_q;
    cavlc_pkg::cavlc_stats_t stat_q;

    cavlc_pkg::coeff_t cur;
    logic              nz;
    logic              mag1;
    logic              is_t1;

    assign cur   = blk_q.coeffs[scan_idx_q];
    assign nz    = (cur != 8'sd0);
    assign mag1  = (cur == 8'sd1) || (cur == -8'sd1);
    // at most three ones, and none after a larger level.
    assign is_t1 = nz && mag1 && !t1_stop_q && (stat_q.trailing_ones != 2'd3);

    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE: if (blk_valid_i) state_next = LOAD;
            LOAD: state_next = SCAN;
            SCAN: if (scan_idx_q == '0) state_next = DONE;
            DONE: if (stat_ready_i) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            scan_idx_q <= '0;
            seen_nz_q  <= 1'b0;
            t1_stop_q  <= 1'b0;
            zero_run_q <= '0;
        end else begin
            state_q <= state_next;
            case (state_q)
                LOAD: begin
                    scan_idx_q <= IDX_W'(N - 1);
                    seen_nz_q  <= 1'b0;
                    t1_stop_q  <= 1'b0;
                    zero_run_q <= '0;
                end
                SCAN: begin
                    scan_idx_q <= scan_idx_q - IDX_W'(1);
                    if (nz) begin
                        seen_nz_q  <= 1'b1;
                        zero_run_q <= '0;
                        if (!is_t1) t1_stop_q <= 1'b1;
                    end else if (seen_nz_q) begin
                        zero_run_q <= zero_run_q + 4'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && blk_valid_i) begin
            blk_q <= blk_i;
        end
        case (state_q)
            LOAD: begin
                stat_q                  <= '0;
                stat_q.topleft_x        <= blk_q.topleft_x;
                stat_q.topleft_y        <= blk_q.topleft_y;
                stat_q.enc_slice_header <= blk_q.enc_slice_header;
                stat_q.enc_mb_header    <= blk_q.enc_mb_header;
            end
            SCAN: begin
                if (nz) begin
                    stat_q.total_coeff <= stat_q.total_coeff + CNT_W'(1);
                    if (is_t1) begin
                        stat_q.t1_signs[stat_q.trailing_ones] <= cur[7];
                        stat_q.trailing_ones <= stat_q.trailing_ones + 2'd1;
                    end else begin
                        stat_q.levels[stat_q.level_cnt[IDX_W-1:0]] <= cur;
                        stat_q.level_cnt <= stat_q.level_cnt + CNT_W'(1);
                    end
                    // zeros since the previous nonzero belong to that one.
                    if (seen_nz_q) begin
                        stat_q.runs[stat_q.run_cnt[IDX_W-1:0]] <= zero_run_q;
                        stat_q.run_cnt <= stat_q.run_cnt + CNT_W'(1);
                    end
                end else if (seen_nz_q) begin
                    stat_q.total_zeros <= stat_q.total_zeros + CNT_W'(1);
                end
            end
            default: ;
        endcase
    end

    assign blk_ready_o  = (state_q == IDLE);
    assign stat_valid_o = (state_q == DONE);
    assign stat_o       = stat_q;

endmodule

// File: logic/cavlc_collect.sv
`include "cavlc_consts.svh"

module cavlc_collect (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`CAVLC_LANES-1:0] lane_valid_i,
    input  cavlc_pkg::cavlc_stats_t lane_stat_i [`CAVLC_LANES],
    output logic [`CAVLC_LANES-1:0] lane_ready_o,
    output logic                    stat_valid_o,
    output cavlc_pkg::cavlc_stats_t stat_o,
    input  logic                    stat_ready_i
);

    localparam int LANES = `CAVLC_LANES;
    localparam int SEL_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [SEL_W-1:0] sel_q;
    logic             xfer;

    assign stat_valid_o = lane_valid_i[sel_q];
    assign stat_o       = lane_stat_i[sel_q];
    assign xfer         = stat_valid_o && stat_ready_i;

    // a lane that finished early waits for its turn.
    always_comb begin
        lane_ready_o        = '0;
        lane_ready_o[sel_q] = stat_ready_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
        end else if (xfer) begin
            if (sel_q == SEL_W'(LANES - 1)) begin
                sel_q <= '0;
            end else begin
                sel_q <= sel_q + SEL_W'(1);
            end
        end
    end

endmodule

// File: logic/cavlc_count_top.sv
`include "cavlc_consts.svh"

module cavlc_count_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    blk_valid_i,
    input  cavlc_pkg::blk_req_t     blk_i,
    output logic                    blk_ready_o,
    output logic                    stat_valid_o,
    output cavlc_pkg::cavlc_stats_t stat_o,
    input  logic                    stat_ready_i
);

    logic                    in_valid;
    logic                    in_ready;
    cavlc_pkg::blk_req_t     in_blk;
    logic [`CAVLC_LANES-1:0] lane_valid;
    logic [`CAVLC_LANES-1:0] lane_ready;
    cavlc_pkg::blk_req_t     lane_blk;
    logic [`CAVLC_LANES-1:0] res_valid;
    logic [`CAVLC_LANES-1:0] res_ready;
    cavlc_pkg::cavlc_stats_t res_stat [`CAVLC_LANES];
    logic                    col_valid;
    logic                    col_ready;
    cavlc_pkg::cavlc_stats_t col_stat;

    cavlc_skid #(.payload_t(cavlc_pkg::blk_req_t)) u_in_skid (
        .clk(clk), .rst(rst),
        .in_valid_i(blk_valid_i), .in_data_i(blk_i), .in_ready_o(blk_ready_o),
        .out_valid_o(in_valid), .out_data_o(in_blk), .out_ready_i(in_ready)
    );

    cavlc_dispatch u_dispatch (
        .clk(clk), .rst(rst),
        .blk_valid_i(in_valid), .blk_i(in_blk), .blk_ready_o(in_ready),
        .lane_valid_o(lane_valid), .lane_blk_o(lane_blk), .lane_ready_i(lane_ready)
    );

    for (genvar g = 0; g < `CAVLC_LANES; g++) begin : g_lane
        cavlc_block_counter u_lane (
            .clk(clk), .rst(rst),
            .blk_valid_i(lane_valid[g]), .blk_i(lane_blk), .blk_ready_o(lane_ready[g]),
            .stat_valid_o(res_valid[g]), .stat_o(res_stat[g]), .stat_ready_i(res_ready[g])
        );
    end

    cavlc_collect u_collect (
        .clk(clk), .rst(rst),
        .lane_valid_i(res_valid), .lane_stat_i(res_stat), .lane_ready_o(res_ready),
        .stat_valid_o(col_valid), .stat_o(col_stat), .stat_ready_i(col_ready)
    );

    cavlc_skid #(.payload_t(cavlc_pkg::cavlc_stats_t)) u_out_skid (
        .clk(clk), .rst(rst),
        .in_valid_i(col_valid), .in_data_i(col_stat), .in_ready_o(col_ready),
        .out_valid_o(stat_valid_o), .out_data_o(stat_o), .out_ready_i(stat_ready_i)
    );

endmodule

// File: tests/cavlc_count_tb.sv
`include "cavlc_consts.svh"

module cavlc_count_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 4;
    localparam int NUM_RECS       = 8;
    localparam int REC_W          = 58;
    localparam int MAX_LATENCY    = 19;
    localparam int TIMEOUT_CYCLES = NUM_RECS * 60 + 200;

    logic                    clk;
    logic                    rst;
    logic                    blk_valid;
    cavlc_pkg::blk_req_t     blk;
    logic                    blk_ready;
    logic                    stat_valid;
    cavlc_pkg::cavlc_stats_t stat;
    logic                    stat_ready;

    logic [15:0] trace_mem [NUM_RECS * REC_W];
    logic [31:0] lfsr_q;
    int          errors;
    int          failed_tests;
    int          results_seen;
    int          gaps [NUM_RECS];

    cavlc_count_top DUT (
        .clk(clk), .rst(rst),
        .blk_valid_i(blk_valid), .blk_i(blk), .blk_ready_o(blk_ready),
        .stat_valid_o(stat_valid), .stat_o(stat), .stat_ready_i(stat_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic rand_bit();
        lfsr_q = lfsr_step(lfsr_q);
        return lfsr_q[0];
    endfunction

    function automatic cavlc_pkg::blk_req_t block_of(input int r);
        cavlc_pkg::blk_req_t b;
        int                  base;
        base               = r * REC_W;
        b.topleft_x        = `CAVLC_POS_W'(trace_mem[base + 1]);
        b.topleft_y        = `CAVLC_POS_W'(trace_mem[base + 2]);
        b.enc_slice_header = trace_mem[base + 3][1];
        b.enc_mb_header    = trace_mem[base + 3][0];
        for (int i = 0; i < `CAVLC_BLK_COEFFS; i++) begin
            b.coeffs[i] = trace_mem[base + 4 + i][7:0];
        end
        return b;
    endfunction

    // position and flags are copied from the request words.
    function automatic cavlc_pkg::cavlc_stats_t stats_of(input int r);
        cavlc_pkg::cavlc_stats_t s;
        int                      base;
        base               = r * REC_W;
        s.total_coeff      = `CAVLC_CNT_W'(trace_mem[base + 20]);
        s.total_zeros      = `CAVLC_CNT_W'(trace_mem[base + 21]);
        s.trailing_ones    = trace_mem[base + 22][1:0];
        s.t1_signs         = trace_mem[base + 23][2:0];
        s.level_cnt        = `CAVLC_CNT_W'(trace_mem[base + 24]);
        s.run_cnt          = `CAVLC_CNT_W'(trace_mem[base + 25]);
        for (int i = 0; i < `CAVLC_BLK_COEFFS; i++) begin
            s.levels[i] = trace_mem[base + 26 + i][7:0];
            s.runs[i]   = trace_mem[base + 42 + i][3:0];
        end
        s.topleft_x        = `CAVLC_POS_W'(trace_mem[base + 1]);
        s.topleft_y        = `CAVLC_POS_W'(trace_mem[base + 2]);
        s.enc_slice_header = trace_mem[base + 3][1];
        s.enc_mb_header    = trace_mem[base + 3][0];
        return s;
    endfunction

    task automatic report_diff(input string name, input logic [127:0] want,
                               input logic [127:0] got);
        $display("CHECK FAILED at %0d ns: %s expected %0h, got %0h", $time, name, want, got);
        errors++;
    endtask

    task automatic check_ctrl(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("CHECK FAILED at %0d ns: %s expected %b, got %b", $time, name, want, got);
            errors++;
        end
    endtask

    task automatic check_stats(input cavlc_pkg::cavlc_stats_t want,
                               input cavlc_pkg::cavlc_stats_t got);
        if (got.total_coeff !== want.total_coeff)
            report_diff("total_coeff", 128'(want.total_coeff), 128'(got.total_coeff));
        if (got.total_zeros !== want.total_zeros)
            report_diff("total_zeros", 128'(want.total_zeros), 128'(got.total_zeros));
        if (got.trailing_ones !== want.trailing_ones)
            report_diff("trailing_ones", 128'(want.trailing_ones), 128'(got.trailing_ones));
        if (got.t1_signs !== want.t1_signs)
            report_diff("t1_signs", 128'(want.t1_signs), 128'(got.t1_signs));
        if (got.level_cnt !== want.level_cnt)
            report_diff("level_cnt", 128'(want.level_cnt), 128'(got.level_cnt));
        if (got.levels !== want.levels)
            report_diff("levels", want.levels, got.levels);
        if (got.run_cnt !== want.run_cnt)
            report_diff("run_cnt", 128'(want.run_cnt), 128'(got.run_cnt));
        if (got.runs !== want.runs)
            report_diff("runs", 128'(want.runs), 128'(got.runs));
        if (got.topleft_x !== want.topleft_x || got.topleft_y !== want.topleft_y)
            report_diff("topleft_x/y", 128'({want.topleft_x, want.topleft_y}),
                        128'({got.topleft_x, got.topleft_y}));
        if ({got.enc_slice_header, got.enc_mb_header} !==
            {want.enc_slice_header, want.enc_mb_header})
            report_diff("header_flags", 128'({want.enc_slice_header, want.enc_mb_header}),
                        128'({got.enc_slice_header, got.enc_mb_header}));
    endtask

    task automatic send_block(input cavlc_pkg::blk_req_t b);
        logic taken;
        blk_valid = 1'b1;
        blk       = b;
        do begin
            @(negedge clk);
            taken = blk_ready;
            @(posedge clk);
            #1;
        end while (!taken);
        blk_valid = 1'b0;
    endtask

    task automatic drive_blocks();
        @(posedge clk);
        #1;
        for (int r = 0; r < NUM_RECS; r++) begin
            repeat (gaps[r]) begin
                @(posedge clk);
                #1;
            end
            send_block(block_of(r));
        end
    endtask

    // sink stalls about one cycle in four.
    task automatic drive_ready();
        forever begin
            @(posedge clk);
            #1;
            stat_ready = rand_bit() | rand_bit();
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: only %0d of %0d results arrived", results_seen, NUM_RECS);
        $display("Errors found");
        $finish;
    end

    initial begin
        int test_errs;
        rst          = 1'b1;
        blk_valid    = 1'b0;
        blk          = '0;
        stat_ready   = 1'b0;
        lfsr_q       = 32'h8efd2380;
        errors       = 0;
        failed_tests = 0;
        results_seen = 0;
        $readmemh("tests/cavlc_trace.txt", trace_mem);
        for (int r = 0; r < NUM_RECS; r++) begin
            gaps[r] = ({rand_bit(), rand_bit()} == 2'b11) ? 3 : 0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_ctrl("stat_valid_o", 1'b0, stat_valid);
        check_ctrl("blk_ready_o", 1'b1, blk_ready);
        $display("test reset: %s", (errors == 0) ? "pass" : "fail");
        if (errors != 0) failed_tests++;
        fork
            drive_blocks();
            drive_ready();
        join_none
        // results must come back in trace order.
        for (int r = 0; r < NUM_RECS; r++) begin
            test_errs = errors;
            do begin
                @(negedge clk);
            end while (!(stat_valid && stat_ready));
            check_stats(stats_of(r), stat);
            results_seen++;
            if (errors > test_errs) failed_tests++;
            $display("test block %0d: %s", trace_mem[r * REC_W],
                     (errors > test_errs) ? "fail" : "pass");
        end
        // no result may follow the last record.
        test_errs = errors;
        for (int c = 0; c <= MAX_LATENCY && errors == test_errs; c++) begin
            @(negedge clk);
            check_ctrl("stat_valid_o", 1'b0, stat_valid);
        end
        if (errors > test_errs) failed_tests++;
        $display("test idle: %s", (errors > test_errs) ? "fail" : "pass");
        $display("summary: %0d tests, %0d failed, %0d check errors",
                 NUM_RECS + 2, failed_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tests/cavlc_trace.txt
// line 1: id, topleft_x, topleft_y, flags (bit1 slice, bit0 mb), coeffs[0..15] zigzag
// line 2: total_coeff, total_zeros, t1, t1_signs, level_cnt, run_cnt, levels[0..15], runs[0..15]
01 000 000 3 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 0 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
02 004 000 0 10 f8 07 06 fb 04 03 fe 02 03 fd 02 02 01 ff 01
10 00 3 2 0d 0f 02 02 fd 03 02 fe 03 04 fb 06 07 f8 10 00 00 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
03 008 004 1 03 01 ff 01 00 01 ff 00 00 00 00 00 00 00 00 00
06 01 3 1 03 05 ff 01 03 00 00 00 00 00 00 00 00 00 00 00 00 00 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0
04 3fc 004 2 05 00 00 00 ff 00 00 01 fc 01 00 00 00 00 00 00
05 05 1 0 04 04 fc 01 ff 05 00 00 00 00 00 00 00 00 00 00 00 00 0 0 2 3 0 0 0 0 0 0 0 0 0 0 0 0
05 010 3f8 0 00 ff 00 02 00 01 00 00 ff 00 00 ff 00 00 00 00
05 07 3 3 02 04 02 ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2 2 1 1 0 0 0 0 0 0 0 0 0 0 0 0
06 2a5 15a 1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 80
01 0f 0 0 01 00 80 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
07 01c 020 2 ff 00 00 00 00 00 00 00 00 00 ff 00 ff 00 ff 00
04 0b 3 7 01 03 ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 1 9 0 0 0 0 0 0 0 0 0 0 0 0 0
08 3ff 3ff 3 01 00 fe 00 00 00 00 00 00 00 00 00 00 00 00 00
02 01 0 0 02 01 fe 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: Makefile
VERILATOR ?= verilator
FLIST     ?= vlog.f
TB_TOP    ?= cavlc_count_tb
RTL_TOP   ?= cavlc_count_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: vlog.f
+incdir+logic
logic/cavlc_pkg.sv
logic/cavlc_skid.sv
logic/cavlc_dispatch.sv
logic/cavlc_block_counter.sv
logic/cavlc_collect.sv
logic/cavlc_count_top.sv
tests/cavlc_count_tb.sv
